// ==== zxuno_iobus.f ====
+incdir+src
src/zxuno_pkg.sv
src/zxuno_regaddr.sv
src/zxuno_cfg_reg.sv
src/zxuno_rasterint.sv
src/zxuno_io_decode.sv
src/zxuno_iobus.sv
sim/zxuno_iobus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the zxuno_iobus testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module zxuno_iobus_tb -Mdir obj_dir -f zxuno_iobus.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vzxuno_iobus_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^TESTS PASSED$'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== sim/zxuno_iobus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zxuno_macros.svh"

module zxuno_iobus_tb;

  import zxuno_pkg::*;

  // about 200 cycles of directed tests plus a wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic        sysclk;
  logic        rst;
  cpu_bus_t    cpu;
  logic [7:0]  ula_dout;
  logic        raster_int_in_progress;
  logic [7:0]  cpudin;
  ay_ctrl_t    ay;
  scndbl_t     scndbl;
  devopts_t    devopts;
  raster_cfg_t raster;

  integer seed = 86;
  int     errors = 0;
  int     checks = 0;
  int     cycle_count = 0;

  zxuno_iobus zxuno_iobus_inst (
    .sysclk                 (sysclk),
    .rst                    (rst),
    .cpu                    (cpu),
    .ula_dout               (ula_dout),
    .raster_int_in_progress (raster_int_in_progress),
    .cpudin                 (cpudin),
    .ay                     (ay),
    .scndbl                 (scndbl),
    .devopts                (devopts),
    .raster                 (raster)
  );

  // 40 ns period
  initial sysclk = 1'b0;
  always #20 sysclk = ~sysclk;

  // watchdog
  always @(posedge sysclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // expected values from the register bit maps
  // --------------------------------------------------------------------------
  function automatic scndbl_t scndbl_of(input logic [7:0] d);
    scndbl_t s;
    s.vga_enable       = d[0];
    s.scanlines_enable = d[1];
    s.freq_option      = d[4:2];
    s.csync_option     = d[5];
    s.cpu_speed        = d[7:6];
    return s;
  endfunction

  function automatic devopts_t devopts_of(input logic [7:0] d);
    devopts_t o;
    o.disable_ay       = d[0];
    o.disable_turboay  = d[1];
    o.disable_7ffd     = d[2];
    o.disable_1ffd     = d[3];
    o.disable_romsel7f = d[4];
    o.disable_romsel1f = d[5];
    o.enable_timexmmu  = d[6];
    o.disable_spisd    = d[7];
    return o;
  endfunction

  function automatic ay_ctrl_t ay_pins(input logic bdir, input logic bc1);
    ay_ctrl_t p;
    p.bdir = bdir;
    p.bc1  = bc1;
    return p;
  endfunction

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_scndbl(input scndbl_t exp, input scndbl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] scndbl expected 0x%h got 0x%h", exp, act);
    end
  endtask

  task automatic check_devopts(input devopts_t exp, input devopts_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] devopts expected 0x%h got 0x%h", exp, act);
    end
  endtask

  task automatic check_raster(input raster_cfg_t exp, input raster_cfg_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] raster expected 0x%h got 0x%h", exp, act);
    end
  endtask

  task automatic check_ay(input string name, input ay_ctrl_t exp, input ay_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // bus tasks start and end 2 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge sysclk);
    #2;
  endtask

  task automatic bus_idle();
    cpu.iorq_n = 1'b1;
    cpu.rd_n   = 1'b1;
    cpu.wr_n   = 1'b1;
    cpu.m1_n   = 1'b1;
  endtask

  task automatic drive_write(input logic [15:0] addr, input logic [7:0] data);
    cpu.addr   = addr;
    cpu.wdata  = data;
    cpu.iorq_n = 1'b0;
    cpu.wr_n   = 1'b0;
  endtask

  // write held 3 cycles then 1 idle
  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    drive_write(addr, data);
    repeat (3) next_cycle();
    bus_idle();
    next_cycle();
  endtask

  // sample while the read strobes are still held
  task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
    cpu.addr   = addr;
    cpu.iorq_n = 1'b0;
    cpu.rd_n   = 1'b0;
    next_cycle();
    data = cpudin;
    bus_idle();
    next_cycle();
  endtask

  task automatic reg_write(input logic [7:0] num, input logic [7:0] data);
    io_write(`ZXUNO_ADDR_PORT, num);
    io_write(`ZXUNO_DATA_PORT, data);
  endtask

  task automatic reg_read(input logic [7:0] num, output logic [7:0] data);
    io_write(`ZXUNO_ADDR_PORT, num);
    io_read(`ZXUNO_DATA_PORT, data);
  endtask

  // data port write paused after its first edge
  task automatic write_one_edge(input logic [7:0] num, input logic [7:0] data);
    io_write(`ZXUNO_ADDR_PORT, num);
    drive_write(`ZXUNO_DATA_PORT, data);
    next_cycle();
  endtask

  task automatic finish_write();
    repeat (2) next_cycle();
    bus_idle();
    next_cycle();
  endtask

  task automatic ay_cycle(input logic [15:0] addr, input logic write, output ay_ctrl_t pins);
    cpu.addr   = addr;
    cpu.iorq_n = 1'b0;
    cpu.wr_n   = !write;
    cpu.rd_n   = write;
    next_cycle();
    pins = ay;
    bus_idle();
    next_cycle();
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic reset_state_test();
    raster_cfg_t exp_r;
    logic [7:0]  got;
    // all ones line and both flags clear
    exp_r.raster_line         = 9'h1FF;
    exp_r.rasterint_enable    = 1'b0;
    exp_r.vretraceint_disable = 1'b0;
    check_scndbl(scndbl_of(8'h00), scndbl);
    check_devopts(devopts_of(8'h00), devopts);
    check_raster(exp_r, raster);
    check_byte("cpudin idle bus", ula_dout, cpudin);
    check_ay("ay idle bus", ay_pins(1'b0, 1'b0), ay);
    io_read(`ZXUNO_ADDR_PORT, got);
    check_byte("cpudin reg number after reset", 8'h00, got);
  endtask

  task automatic addr_latch_test();
    logic [31:0] rnd;
    logic [7:0]  got;
    rnd = $random(seed);
    io_write(`ZXUNO_ADDR_PORT, rnd[7:0]);
    io_read(`ZXUNO_ADDR_PORT, got);
    check_byte("cpudin reg number readback", rnd[7:0], got);
    // nothing claims register 0x40
    reg_read(8'h40, got);
    check_byte("cpudin unused reg", ula_dout, got);
  endtask

  task automatic cfg_regs_test();
    logic [31:0] rnd;
    logic [7:0]  got;
    logic [7:0]  sd_cur;
    logic [7:0]  dv_cur;
    // both still hold reset values
    sd_cur = 8'h00;
    dv_cur = 8'h00;
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      // scandoubler write leaves device options alone
      write_one_edge(`REG_SCNDBLCTRL, rnd[7:0]);
      sd_cur = rnd[7:0];
      check_scndbl(scndbl_of(sd_cur), scndbl);
      check_devopts(devopts_of(dv_cur), devopts);
      finish_write();
      // device options
      write_one_edge(`REG_DEVOPTIONS, rnd[15:8]);
      dv_cur = rnd[15:8];
      check_devopts(devopts_of(dv_cur), devopts);
      check_scndbl(scndbl_of(sd_cur), scndbl);
      finish_write();
      reg_read(`REG_SCNDBLCTRL, got);
      check_byte("cpudin reg 0x0b", sd_cur, got);
      reg_read(`REG_DEVOPTIONS, got);
      check_byte("cpudin reg 0x0e", dv_cur, got);
    end
  endtask

  task automatic raster_test();
    logic [31:0] rnd;
    logic [7:0]  got;
    logic [8:0]  line;
    logic [7:0]  ctrl;
    raster_cfg_t exp_r;
    rnd  = $random(seed);
    line = rnd[8:0];
    // bit 0 line msb and bits 2:1 the two flags
    // upper bits random and ignored
    ctrl = {rnd[16:10], line[8]};
    reg_write(`REG_RASTERLINE, line[7:0]);
    reg_write(`REG_RASTERCTRL, ctrl);
    exp_r.raster_line         = line;
    exp_r.rasterint_enable    = ctrl[1];
    exp_r.vretraceint_disable = ctrl[2];
    check_raster(exp_r, raster);
    reg_read(`REG_RASTERLINE, got);
    check_byte("cpudin reg 0x0c", line[7:0], got);
    // bit 7 follows the live status input
    for (int s = 0; s < 2; s++) begin
      raster_int_in_progress = s[0];
      reg_read(`REG_RASTERCTRL, got);
      check_byte("cpudin reg 0x0d", {s[0], 4'b0000, ctrl[2:0]}, got);
    end
    raster_int_in_progress = 1'b0;
  endtask

  task automatic ay_decode_test();
    ay_ctrl_t got_ay;
    logic     on;
    reg_write(`REG_DEVOPTIONS, 8'h00);
    for (int pass = 0; pass < 2; pass++) begin
      // second pass with the ay switched off
      if (pass == 1) begin
        reg_write(`REG_DEVOPTIONS, 8'h01);
        check_devopts(devopts_of(8'h01), devopts);
      end
      on = (pass == 0);
      ay_cycle(16'hFFFD, 1'b1, got_ay);
      check_ay("ay write 0xfffd", ay_pins(on, on), got_ay);
      ay_cycle(16'hBFFD, 1'b1, got_ay);
      check_ay("ay write 0xbffd", ay_pins(on, 1'b0), got_ay);
      ay_cycle(16'hFFFD, 1'b0, got_ay);
      check_ay("ay read 0xfffd", ay_pins(1'b0, on), got_ay);
      check_ay("ay idle bus", ay_pins(1'b0, 1'b0), ay);
    end
  endtask

  task automatic intack_test();
    logic [7:0] got;
    io_write(`ZXUNO_ADDR_PORT, `REG_SCNDBLCTRL);
    // address readback also matches here and intack outranks it
    cpu.addr   = `ZXUNO_ADDR_PORT;
    cpu.iorq_n = 1'b0;
    cpu.m1_n   = 1'b0;
    cpu.rd_n   = 1'b0;
    next_cycle();
    check_byte("cpudin intack", 8'hFF, cpudin);
    bus_idle();
    next_cycle();
    io_read(`ZXUNO_ADDR_PORT, got);
    check_byte("cpudin reg number after intack", `REG_SCNDBLCTRL, got);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    cpu = '0;
    bus_idle();
    ula_dout               = 8'hC7;
    raster_int_in_progress = 1'b0;
    rst                    = 1'b1;
    repeat (5) @(posedge sysclk);
    #2;
    rst = 1'b0;
    reset_state_test();
    addr_latch_test();
    cfg_regs_test();
    raster_test();
    ay_decode_test();
    intack_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/zxuno_iobus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zxuno_macros.svh"

module zxuno_iobus (
  input  wire logic                sysclk,
  input  wire logic                rst,
  input  wire zxuno_pkg::cpu_bus_t cpu,
  input  wire logic [7:0]          ula_dout,
  input  wire logic                raster_int_in_progress,
  output logic [7:0]               cpudin,
  output zxuno_pkg::ay_ctrl_t      ay,
  output zxuno_pkg::scndbl_t       scndbl,
  output zxuno_pkg::devopts_t      devopts,
  output zxuno_pkg::raster_cfg_t   raster
);

  import zxuno_pkg::*;

  // shared register bank access
  reg_access_t regs;

  // readback sources, one per block
  rd_src_t addr_rd;
  rd_src_t scndbl_rd;
  rd_src_t raster_rd;
  rd_src_t devopts_rd;

  // --------------------------------------------------------------------------
  // register select and data port strobes
  // --------------------------------------------------------------------------
  zxuno_regaddr zxuno_regaddr_inst (
    .sysclk (sysclk),
    .rst    (rst),
    .cpu    (cpu),
    .regs   (regs),
    .rd     (addr_rd)
  );

  // --------------------------------------------------------------------------
  // configuration registers
  // --------------------------------------------------------------------------
  // scandoubler and cpu speed, cleared on reset
  zxuno_cfg_reg #(
    .payload_t   (scndbl_t),
    .REG_NUM     (`REG_SCNDBLCTRL),
    .RESET_VALUE ('0)
  ) scndbl_reg_inst (
    .sysclk (sysclk),
    .rst    (rst),
    .cpu    (cpu),
    .regs   (regs),
    .value  (scndbl),
    .rd     (scndbl_rd)
  );

  // all devices enabled after reset
  zxuno_cfg_reg #(
    .payload_t   (devopts_t),
    .REG_NUM     (`REG_DEVOPTIONS),
    .RESET_VALUE ('0)
  ) devopts_reg_inst (
    .sysclk (sysclk),
    .rst    (rst),
    .cpu    (cpu),
    .regs   (regs),
    .value  (devopts),
    .rd     (devopts_rd)
  );

  // raster line and control pair
  zxuno_rasterint zxuno_rasterint_inst (
    .sysclk                 (sysclk),
    .rst                    (rst),
    .cpu                    (cpu),
    .regs                   (regs),
    .raster_int_in_progress (raster_int_in_progress),
    .raster                 (raster),
    .rd                     (raster_rd)
  );

  // --------------------------------------------------------------------------
  // ay decode and cpu input bus
  // --------------------------------------------------------------------------
  zxuno_io_decode zxuno_io_decode_inst (
    .cpu        (cpu),
    .disable_ay (devopts.disable_ay),
    .addr_rd    (addr_rd),
    .scndbl_rd  (scndbl_rd),
    .raster_rd  (raster_rd),
    .devopts_rd (devopts_rd),
    .ula_dout   (ula_dout),
    .cpudin     (cpudin),
    .ay         (ay)
  );

endmodule

`default_nettype wire

// ==== src/zxuno_io_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zxuno_macros.svh"

module zxuno_io_decode (
  input  wire zxuno_pkg::cpu_bus_t cpu,
  input  wire logic                disable_ay,
  input  wire zxuno_pkg::rd_src_t  addr_rd,
  input  wire zxuno_pkg::rd_src_t  scndbl_rd,
  input  wire zxuno_pkg::rd_src_t  raster_rd,
  input  wire zxuno_pkg::rd_src_t  devopts_rd,
  input  wire logic [7:0]          ula_dout,
  output logic [7:0]               cpudin,
  output zxuno_pkg::ay_ctrl_t      ay
);

  logic intack;
  logic ay_port;

  // interrupt acknowledge cycle
  assign intack = !cpu.iorq_n && !cpu.m1_n;

  // --------------------------------------------------------------------------
  // ay chip select
  // --------------------------------------------------------------------------
  //   bdir bc1
  //    0    0   inactive
  //    0    1   read
  //    1    0   write data
  //    1    1   latch address
  // partial decode, a15 high and a1:a0 = 01
  assign ay_port = cpu.addr[15] && (cpu.addr[1:0] == 2'b01) && !cpu.iorq_n && !disable_ay;

  always_comb begin
    ay.bdir = ay_port && !cpu.wr_n;
    // a14 splits 0xfffd from 0xbffd
    ay.bc1  = ay_port && cpu.addr[14];
  end

  // --------------------------------------------------------------------------
  // cpu read data mux
  // --------------------------------------------------------------------------
  // first match wins, ula data when nothing claims the bus
  always_comb begin
    case (1'b1)
      intack:        cpudin = `INTACK_DATA;
      addr_rd.oe:    cpudin = addr_rd.data;
      scndbl_rd.oe:  cpudin = scndbl_rd.data;
      raster_rd.oe:  cpudin = raster_rd.data;
      devopts_rd.oe: cpudin = devopts_rd.data;
      default:       cpudin = ula_dout;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/zxuno_rasterint.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zxuno_macros.svh"

module zxuno_rasterint (
  input  wire logic                   sysclk,
  input  wire logic                   rst,
  input  wire zxuno_pkg::cpu_bus_t    cpu,
  input  wire zxuno_pkg::reg_access_t regs,
  input  wire logic                   raster_int_in_progress,
  output zxuno_pkg::raster_cfg_t      raster,
  output zxuno_pkg::rd_src_t          rd
);

  logic       line_sel;
  logic       ctrl_sel;
  logic [8:0] line_q;
  logic       rint_en_q;
  logic       vret_dis_q;

  assign line_sel = (regs.addr == `REG_RASTERLINE);
  assign ctrl_sel = (regs.addr == `REG_RASTERCTRL);

  // --------------------------------------------------------------------------
  // register pair
  // --------------------------------------------------------------------------
  // 0x0c low byte of the line
  // 0x0d line bit 8, enable, vretrace disable
  always_ff @(posedge sysclk) begin
    if (rst) begin
      line_q     <= `RASTERLINE_RESET;
      rint_en_q  <= 1'b0;
      vret_dis_q <= 1'b0;
    end else if (regs.regwr) begin
      if (line_sel) begin
        line_q[7:0] <= cpu.wdata;
      end
      if (ctrl_sel) begin
        line_q[8]  <= cpu.wdata[0];
        rint_en_q  <= cpu.wdata[1];
        vret_dis_q <= cpu.wdata[2];
      end
    end
  end

  // settings out to the video side
  always_comb begin
    raster.raster_line         = line_q;
    raster.rasterint_enable    = rint_en_q;
    raster.vretraceint_disable = vret_dis_q;
  end

  // --------------------------------------------------------------------------
  // readback
  // --------------------------------------------------------------------------
  always_comb begin
    rd.oe   = regs.regrd && (line_sel || ctrl_sel);
    rd.data = line_q[7:0];
    if (ctrl_sel) begin
      // bit 7 is live status, not stored
      rd.data = {raster_int_in_progress, 4'b0000, vret_dis_q, rint_en_q, line_q[8]};
    end
  end

endmodule

`default_nettype wire

// ==== src/zxuno_cfg_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module zxuno_cfg_reg #(
  parameter type        payload_t   = logic [7:0],
  parameter logic [7:0] REG_NUM     = 8'h00,
  parameter payload_t   RESET_VALUE = '0
) (
  input  wire logic                   sysclk,
  input  wire logic                   rst,
  input  wire zxuno_pkg::cpu_bus_t    cpu,
  input  wire zxuno_pkg::reg_access_t regs,
  output payload_t                    value,
  output zxuno_pkg::rd_src_t          rd
);

  // this register selected
  logic hit;

  assign hit = (regs.addr == REG_NUM);

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------
  // write data maps bit for bit onto the payload
  always_ff @(posedge sysclk) begin
    if (rst) begin
      value <= RESET_VALUE;
    end else if (regs.regwr && hit) begin
      value <= payload_t'(cpu.wdata);
    end
  end

  // --------------------------------------------------------------------------
  // readback
  // --------------------------------------------------------------------------
  always_comb begin
    rd.oe   = regs.regrd && hit;
    // payload is a full byte
    rd.data = value;
  end

endmodule

`default_nettype wire

// ==== src/zxuno_regaddr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zxuno_macros.svh"

module zxuno_regaddr (
  input  wire logic                   sysclk,
  input  wire logic                   rst,
  input  wire zxuno_pkg::cpu_bus_t    cpu,
  output zxuno_pkg::reg_access_t      regs,
  output zxuno_pkg::rd_src_t          rd
);

  // --------------------------------------------------------------------------
  // port decode
  // --------------------------------------------------------------------------
  logic       addr_port_hit;
  logic       data_port_hit;
  logic [7:0] reg_num;

  // full 16 bit compare, both ports share the low byte
  assign addr_port_hit = !cpu.iorq_n && (cpu.addr == `ZXUNO_ADDR_PORT);
  assign data_port_hit = !cpu.iorq_n && (cpu.addr == `ZXUNO_DATA_PORT);

  // --------------------------------------------------------------------------
  // register number latch
  // --------------------------------------------------------------------------
  // reloads on every edge of a long write, same value each time
  always_ff @(posedge sysclk) begin
    if (rst) begin
      reg_num <= 8'h00;
    end else if (addr_port_hit && !cpu.wr_n) begin
      reg_num <= cpu.wdata;
    end
  end

  // strobes to the register bank
  always_comb begin
    regs.addr  = reg_num;
    // level strobes, no edge detect
    regs.regrd = data_port_hit && !cpu.rd_n;
    regs.regwr = data_port_hit && !cpu.wr_n;
  end

  // readback of the select port
  always_comb begin
    rd.oe   = addr_port_hit && !cpu.rd_n;
    rd.data = reg_num;
  end

endmodule

`default_nettype wire

// ==== src/zxuno_pkg.sv ====
`default_nettype none

package zxuno_pkg;

  // one cpu bus cycle, active low strobes
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
  } cpu_bus_t;

  // current register number plus data port strobes
  typedef struct packed {
    logic [7:0] addr;
    logic       regrd;
    logic       regwr;
  } reg_access_t;

  // one candidate for the cpu input bus
  typedef struct packed {
    logic       oe;
    logic [7:0] data;
  } rd_src_t;

  // scandoubler and speed control, msb first
  typedef struct packed {
    logic [1:0] cpu_speed;
    logic       csync_option;
    logic [2:0] freq_option;
    logic       scanlines_enable;
    logic       vga_enable;
  } scndbl_t;

  // device enables, bit 7 down to bit 0
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } devopts_t;

  // raster interrupt settings
  typedef struct packed {
    logic [8:0] raster_line;
    logic       rasterint_enable;
    logic       vretraceint_disable;
  } raster_cfg_t;

  // ay chip strobes, bc2 is tied high on the chip
  typedef struct packed {
    logic bdir;
    logic bc1;
  } ay_ctrl_t;

endpackage

`default_nettype wire

// ==== src/zxuno_macros.svh ====
`ifndef ZXUNO_MACROS_SVH
`define ZXUNO_MACROS_SVH

// --------------------------------------------------------------------------
// cpu i/o ports of the register bank
// --------------------------------------------------------------------------
// select port, takes the register number
`define ZXUNO_ADDR_PORT 16'hFC3B
// data port, reaches the selected register
`define ZXUNO_DATA_PORT 16'hFD3B

// --------------------------------------------------------------------------
// register numbers behind the data port
// --------------------------------------------------------------------------
`define REG_SCNDBLCTRL 8'h0B
`define REG_RASTERLINE 8'h0C
`define REG_RASTERCTRL 8'h0D
`define REG_DEVOPTIONS 8'h0E

// raster line out of reset, beyond the last visible line
`define RASTERLINE_RESET 9'h1FF
// data bus value during a maskable interrupt acknowledge
`define INTACK_DATA 8'hFF

`endif
